/* rtl/channel_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_sequencer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 fm_start,
  input  wire logic                 pixel_done,
  output logic                      sa_en,
  output logic                      sa_reset,
  output logic                      channel_out_en,
  output kernel_ctrl_pkg::row_idx_t row_idx,
  output logic                      sum_e_receive_en,
  output logic                      sum_e_receive_reset,
  output logic                      seq_done
);

  logic                        seq_run;
  logic                        seq_active;
  kernel_ctrl_pkg::seq_count_t seq_count;
  logic                        sa_hold;
  // count windows, one cycle ahead of the registered flags
  logic                        out_window;
  logic                        rx_window;
  logic                        sa_stop;
  logic                        rx_last;

  ////////////////////
  // channel count
  ////////////////////
  // pixel_done is count 0
  assign seq_active = seq_run || pixel_done;
  assign seq_done = seq_active && (seq_count == kernel_ctrl_pkg::SEQ_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      seq_run <= 1'b0;
    end else if (seq_done) begin
      seq_run <= 1'b0;
    end else if (pixel_done) begin
      seq_run <= 1'b1;
    end
  end

  // wraps to 0 after SEQ_LAST, stays 0 when idle
  always_ff @(posedge clk) begin
    if (reset) begin
      seq_count <= '0;
    end else if (seq_done) begin
      seq_count <= '0;
    end else if (seq_active) begin
      seq_count <= seq_count + 6'd1;
    end
  end

  // decode from the current count
  assign sa_stop = seq_active && (seq_count == kernel_ctrl_pkg::SA_STOP_COUNT);
  assign out_window = seq_active &&
                      (seq_count >= kernel_ctrl_pkg::SEQ_OUT_OPEN) &&
                      (seq_count < kernel_ctrl_pkg::SEQ_OUT_CLOSE);
  assign rx_window = seq_active &&
                     (seq_count > kernel_ctrl_pkg::SEQ_OUT_OPEN) &&
                     (seq_count <= kernel_ctrl_pkg::SEQ_OUT_CLOSE);
  assign rx_last = seq_active && (seq_count == kernel_ctrl_pkg::SEQ_LAST - 6'd1);

  ////////////////////
  // systolic array
  ////////////////////
  // held from start through count 30
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_hold <= 1'b0;
    end else if (fm_start) begin
      sa_hold <= 1'b1;
    end else if (sa_stop) begin
      sa_hold <= 1'b0;
    end
  end

  // start pulse enables the array in the same cycle
  assign sa_en = sa_hold || fm_start;

  always_ff @(posedge clk) begin
    if (reset) begin
      sa_reset <= 1'b0;
    end else begin
      sa_reset <= sa_stop;
    end
  end

  ////////////////////
  // output window
  ////////////////////
  // channel_out_en over counts 16..31
  // row_idx and receive enable over 17..32
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_out_en      <= 1'b0;
      sum_e_receive_en    <= 1'b0;
      sum_e_receive_reset <= 1'b0;
      row_idx             <= '0;
    end else begin
      channel_out_en      <= out_window;
      sum_e_receive_en    <= rx_window;
      sum_e_receive_reset <= rx_last;
      // row 1 at count 17, row 16 at count 32
      row_idx <= rx_window ? (seq_count - kernel_ctrl_pkg::SEQ_OUT_OPEN) : 6'd0;
    end
  end

endmodule

`default_nettype wire

/* rtl/kernel_ctrl_pkg.sv */
`default_nettype none

package kernel_ctrl_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int TILE_LEN_W = 16;
  localparam int PIXEL_CNT_W = 16;
  localparam int SEQ_CNT_W = 6;
  localparam int ROW_IDX_W = 6;
  localparam int MODE_W = 4;

  // feature-map words per tile minus two
  typedef logic [TILE_LEN_W-1:0] tile_len_t;
  typedef logic [PIXEL_CNT_W-1:0] pixel_count_t;
  typedef logic [SEQ_CNT_W-1:0] seq_count_t;
  // output channel of the array
  typedef logic [ROW_IDX_W-1:0] row_idx_t;
  typedef logic [MODE_W-1:0] mode_t;

  ////////////////////
  // counts and modes
  ////////////////////
  // layer mode that runs the multiplier array
  localparam mode_t MODE_MULT = 4'd1;
  // channel sequencer landmarks
  localparam seq_count_t SEQ_OUT_OPEN = 6'd15;
  localparam seq_count_t SEQ_OUT_CLOSE = 6'd31;
  localparam seq_count_t SA_STOP_COUNT = 6'd30;
  localparam seq_count_t SEQ_LAST = 6'd33;
  // sum-mult-e, bias, relu-scale, conv fifo
  localparam int POST_STAGES = 4;

  ////////////////////
  // control bundles
  ////////////////////
  typedef struct packed {
    mode_t     mode;
    tile_len_t tile_len;
  } kernel_cfg_t;

  typedef struct packed {
    logic     sa_en;
    logic     sa_reset;
    logic     channel_out_en;
    logic     channel_out_reset;
    row_idx_t row_idx;
  } sa_ctrl_t;

  typedef struct packed {
    logic sum_e_receive_en;
    logic sum_e_receive_reset;
    logic sum_mult_e_en;
    logic sum_mult_e_reset;
    logic product_add_bias_en;
    logic product_add_bias_reset;
    logic relu_scale_en;
    logic relu_scale_reset;
    logic conv_fifo_en;
    logic mult_array_mode;
    logic tile_done;
  } post_ctrl_t;

endpackage

`default_nettype wire

/* rtl/kernel_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl_top (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         fm_start,
  input  wire kernel_ctrl_pkg::kernel_cfg_t cfg_init,
  output kernel_ctrl_pkg::sa_ctrl_t         sa_ctrl,
  output kernel_ctrl_pkg::post_ctrl_t       post_ctrl
);

  kernel_ctrl_pkg::mode_t      mode;
  logic                        pixel_done;
  logic                        channel_out_reset;
  logic                        sa_en;
  logic                        sa_reset;
  logic                        channel_out_en;
  kernel_ctrl_pkg::row_idx_t   row_idx;
  logic                        sum_e_receive_en;
  logic                        sum_e_receive_reset;
  logic                        seq_done;
  kernel_ctrl_pkg::post_ctrl_t post_pipe;

  ////////////////////
  // stages
  ////////////////////
  pixel_window_stage u_pixel (
    .clk               (clk),
    .reset             (reset),
    .fm_start          (fm_start),
    .cfg_init          (cfg_init),
    .mode              (mode),
    .pixel_done        (pixel_done),
    .channel_out_reset (channel_out_reset)
  );

  channel_sequencer u_seq (
    .clk                 (clk),
    .reset               (reset),
    .fm_start            (fm_start),
    .pixel_done          (pixel_done),
    .sa_en               (sa_en),
    .sa_reset            (sa_reset),
    .channel_out_en      (channel_out_en),
    .row_idx             (row_idx),
    .sum_e_receive_en    (sum_e_receive_en),
    .sum_e_receive_reset (sum_e_receive_reset),
    .seq_done            (seq_done)
  );

  postproc_enable_pipe u_post (
    .clk                 (clk),
    .reset               (reset),
    .mode                (mode),
    .sum_e_receive_en    (sum_e_receive_en),
    .sum_e_receive_reset (sum_e_receive_reset),
    .seq_done            (seq_done),
    .post                (post_pipe)
  );

  ////////////////////
  // output bundles
  ////////////////////
  // channel_out_reset from the pixel stage
  assign sa_ctrl = '{
    sa_en:             sa_en,
    sa_reset:          sa_reset,
    channel_out_en:    channel_out_en,
    channel_out_reset: channel_out_reset,
    row_idx:           row_idx
  };

  // receive strobes straight from the sequencer
  assign post_ctrl = '{
    sum_e_receive_en:       sum_e_receive_en,
    sum_e_receive_reset:    sum_e_receive_reset,
    sum_mult_e_en:          post_pipe.sum_mult_e_en,
    sum_mult_e_reset:       post_pipe.sum_mult_e_reset,
    product_add_bias_en:    post_pipe.product_add_bias_en,
    product_add_bias_reset: post_pipe.product_add_bias_reset,
    relu_scale_en:          post_pipe.relu_scale_en,
    relu_scale_reset:       post_pipe.relu_scale_reset,
    conv_fifo_en:           post_pipe.conv_fifo_en,
    mult_array_mode:        post_pipe.mult_array_mode,
    tile_done:              post_pipe.tile_done
  };

endmodule

`default_nettype wire

/* rtl/pixel_window_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_window_stage (
  input  wire logic                         clk,
  input  wire logic                         reset,
  input  wire logic                         fm_start,
  input  wire kernel_ctrl_pkg::kernel_cfg_t cfg_init,
  output kernel_ctrl_pkg::mode_t            mode,
  output logic                              pixel_done,
  output logic                              channel_out_reset
);

  kernel_ctrl_pkg::kernel_cfg_t  cfg;
  logic                          run;
  logic                          active;
  kernel_ctrl_pkg::pixel_count_t pixel_count;

  ////////////////////
  // configuration
  ////////////////////
  // sampled every cycle reset is held, frozen after
  always_ff @(posedge clk) begin
    if (reset) begin
      cfg <= cfg_init;
    end
  end

  assign mode = cfg.mode;

  ////////////////////
  // pixel window
  ////////////////////
  // start pulse counts as the first word
  assign active = fm_start || run;
  // last word of the tile, N+1
  assign pixel_done = active && (pixel_count == cfg.tile_len + 16'd1);

  // a start while running is ignored
  always_ff @(posedge clk) begin
    if (reset) begin
      run <= 1'b0;
    end else if (pixel_done) begin
      run <= 1'b0;
    end else if (fm_start) begin
      run <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_count <= '0;
    end else if (pixel_done) begin
      pixel_count <= '0;
    end else if (active) begin
      pixel_count <= pixel_count + 16'd1;
    end
  end

  // registered off count N so it lands with pixel_done
  always_ff @(posedge clk) begin
    if (reset) begin
      channel_out_reset <= 1'b0;
    end else begin
      channel_out_reset <= active && (pixel_count == cfg.tile_len);
    end
  end

endmodule

`default_nettype wire

/* rtl/postproc_enable_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module postproc_enable_pipe (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire kernel_ctrl_pkg::mode_t mode,
  input  wire logic                   sum_e_receive_en,
  input  wire logic                   sum_e_receive_reset,
  input  wire logic                   seq_done,
  output kernel_ctrl_pkg::post_ctrl_t post
);

  // stage 0 sum-mult-e, 1 bias, 2 relu-scale, 3 conv fifo
  logic [kernel_ctrl_pkg::POST_STAGES-1:0] en_q;
  logic [kernel_ctrl_pkg::POST_STAGES-1:0] en_src;
  // conv fifo has no reset
  logic [kernel_ctrl_pkg::POST_STAGES-2:0] rst_q;
  logic [kernel_ctrl_pkg::POST_STAGES-2:0] rst_src;
  logic [kernel_ctrl_pkg::POST_STAGES-1:0] done_q;
  logic                                    mult_q;
  logic                                    mult_next;

  // each stage fed by the one before it
  assign en_src = {en_q[kernel_ctrl_pkg::POST_STAGES-2:0], sum_e_receive_en};
  assign rst_src = {rst_q[kernel_ctrl_pkg::POST_STAGES-3:0], sum_e_receive_reset};

  ////////////////////
  // enable ladder
  ////////////////////
  // enable holds during the stage's own reset cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      en_q  <= '0;
      rst_q <= '0;
    end else begin
      for (int i = 0; i < kernel_ctrl_pkg::POST_STAGES - 1; i++) begin
        if (rst_q[i]) begin
          rst_q[i] <= 1'b0;
        end else begin
          en_q[i]  <= en_src[i];
          rst_q[i] <= rst_src[i];
        end
      end
      // fifo write enable, plain delay
      en_q[kernel_ctrl_pkg::POST_STAGES-1] <= en_src[kernel_ctrl_pkg::POST_STAGES-1];
    end
  end

  // next value of stage 0 enable, gated by mode
  assign mult_next = (mode == kernel_ctrl_pkg::MODE_MULT) &&
                     (rst_q[0] ? en_q[0] : sum_e_receive_en);

  // mult mode, then tile done four cycles after seq_done
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_q <= 1'b0;
      done_q <= '0;
    end else begin
      mult_q <= mult_next;
      done_q <= {done_q[kernel_ctrl_pkg::POST_STAGES-2:0], seq_done};
    end
  end

  ////////////////////
  // outputs
  ////////////////////
  // receive strobes come from the sequencer at the top
  always_comb begin
    post                        = '0;
    post.sum_mult_e_en          = en_q[0];
    post.sum_mult_e_reset       = rst_q[0];
    post.product_add_bias_en    = en_q[1];
    post.product_add_bias_reset = rst_q[1];
    post.relu_scale_en          = en_q[2];
    post.relu_scale_reset       = rst_q[2];
    post.conv_fifo_en           = en_q[3];
    post.mult_array_mode        = mult_q;
    post.tile_done              = done_q[kernel_ctrl_pkg::POST_STAGES-1];
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tb
rtl/kernel_ctrl_pkg.sv
rtl/pixel_window_stage.sv
rtl/channel_sequencer.sv
rtl/postproc_enable_pipe.sv
rtl/kernel_ctrl_top.sv
tb/kernel_ctrl_tb.sv

/* tb/kernel_ctrl_ref.svh */
`ifndef KERNEL_CTRL_REF_SVH
`define KERNEL_CTRL_REF_SVH
`default_nettype none

// expected sa_ctrl and post_ctrl side by side
typedef struct packed {
  kernel_ctrl_pkg::sa_ctrl_t   sa;
  kernel_ctrl_pkg::post_ctrl_t post;
} ctrl_expect_t;

// one tile, t cycles after its start, all zero before it
// j counts from the last pixel cycle N+1
function automatic ctrl_expect_t tile_expect(input int t, input int n,
                                             input kernel_ctrl_pkg::mode_t mode);
  ctrl_expect_t e;
  int           j;
  e = '0;
  j = t - (n + 1);
  if (t >= 0) begin
    // array runs from the start pulse through count 30
    e.sa.sa_en             = (j <= 30);
    e.sa.sa_reset          = (j == 31);
    e.sa.channel_out_en    = (j >= 16) && (j <= 31);
    e.sa.channel_out_reset = (j == 0);
    // rows 1..16
    if ((j >= 17) && (j <= 32)) begin
      e.sa.row_idx = 6'(j - 16);
    end
    // receive window
    e.post.sum_e_receive_en    = (j >= 17) && (j <= 32);
    e.post.sum_e_receive_reset = (j == 33);
    // ladder, one cycle per stage
    e.post.sum_mult_e_en          = (j >= 18) && (j <= 33);
    e.post.sum_mult_e_reset       = (j == 34);
    e.post.product_add_bias_en    = (j >= 19) && (j <= 34);
    e.post.product_add_bias_reset = (j == 35);
    e.post.relu_scale_en          = (j >= 20) && (j <= 35);
    e.post.relu_scale_reset       = (j == 36);
    e.post.conv_fifo_en           = (j >= 21) && (j <= 36);
    // multiplier only in mult mode
    e.post.mult_array_mode = (mode == kernel_ctrl_pkg::MODE_MULT) && e.post.sum_mult_e_en;
    e.post.tile_done       = (j == 37);
  end
  return e;
endfunction

// current tile plus the one still draining
function automatic ctrl_expect_t expected_ctrl(input int offset, input int n,
                                               input kernel_ctrl_pkg::mode_t mode,
                                               input int prev_offset);
  ctrl_expect_t cur;
  ctrl_expect_t prev;
  cur = tile_expect(offset, n, mode);
  prev = tile_expect(prev_offset, n, mode);
  // windows of two tiles never collide so OR merges them
  return cur | prev;
endfunction

`default_nettype wire
`endif

/* tb/kernel_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl_tb;

  logic                         clk;
  logic                         reset;
  logic                         fm_start;
  kernel_ctrl_pkg::kernel_cfg_t cfg_init;
  kernel_ctrl_pkg::sa_ctrl_t    sa_ctrl;
  kernel_ctrl_pkg::post_ctrl_t  post_ctrl;

  // cycle offsets of the current and previous tile, -1 when none
  int                     cur_off;
  int                     prev_off;
  int                     exp_n;
  kernel_ctrl_pkg::mode_t exp_mode;
  logic                   checking;

  int seed;
  int cycle_count;
  int timeout_limit;
  int errors;
  int tests_passed;
  int tests_failed;
  int done_pulses;
  int rand_n [5];
  int rand_mode [5];

  `include "kernel_ctrl_ref.svh"

  kernel_ctrl_top UUT (
    .clk       (clk),
    .reset     (reset),
    .fm_start  (fm_start),
    .cfg_init  (cfg_init),
    .sa_ctrl   (sa_ctrl),
    .post_ctrl (post_ctrl)
  );

  ////////////////////
  // clock and timeout
  ////////////////////
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_limit) begin
      $display("timeout: run went past %0d cycles without finishing", timeout_limit);
      $display("Simulation FAILED");
      $finish;
    end
  end

  ////////////////////
  // checking
  ////////////////////
  task automatic check_bit(input string name, input logic want, input logic got);
    assert (got === want) else begin
      $display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, want, got);
      errors++;
    end
  endtask

  task automatic check_pulses(input int want);
    assert (done_pulses == want) else begin
      $display("wrong number of tile_done pulses: expected %0d, saw %0d", want, done_pulses);
      errors++;
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin : compare
    ctrl_expect_t want;
    if (checking) begin
      want = expected_ctrl(cur_off, exp_n, exp_mode, prev_off);
      check_bit("sa_en", want.sa.sa_en, sa_ctrl.sa_en);
      check_bit("sa_reset", want.sa.sa_reset, sa_ctrl.sa_reset);
      check_bit("channel_out_en", want.sa.channel_out_en, sa_ctrl.channel_out_en);
      check_bit("channel_out_reset", want.sa.channel_out_reset, sa_ctrl.channel_out_reset);
      assert (sa_ctrl.row_idx === want.sa.row_idx) else begin
        $display("CHECK FAILED t=%0t row_idx expected %0d actual %0d",
                 $time, want.sa.row_idx, sa_ctrl.row_idx);
        errors++;
      end
      check_bit("sum_e_receive_en", want.post.sum_e_receive_en, post_ctrl.sum_e_receive_en);
      check_bit("sum_e_receive_reset", want.post.sum_e_receive_reset,
                post_ctrl.sum_e_receive_reset);
      check_bit("sum_mult_e_en", want.post.sum_mult_e_en, post_ctrl.sum_mult_e_en);
      check_bit("sum_mult_e_reset", want.post.sum_mult_e_reset, post_ctrl.sum_mult_e_reset);
      check_bit("product_add_bias_en", want.post.product_add_bias_en,
                post_ctrl.product_add_bias_en);
      check_bit("product_add_bias_reset", want.post.product_add_bias_reset,
                post_ctrl.product_add_bias_reset);
      check_bit("relu_scale_en", want.post.relu_scale_en, post_ctrl.relu_scale_en);
      check_bit("relu_scale_reset", want.post.relu_scale_reset, post_ctrl.relu_scale_reset);
      check_bit("conv_fifo_en", want.post.conv_fifo_en, post_ctrl.conv_fifo_en);
      check_bit("mult_array_mode", want.post.mult_array_mode, post_ctrl.mult_array_mode);
      check_bit("tile_done", want.post.tile_done, post_ctrl.tile_done);
      if (post_ctrl.tile_done === 1'b1) begin
        done_pulses++;
      end
      // advance both tiles one cycle
      if (cur_off >= 0) begin
        cur_off++;
      end
      if (prev_off >= 0) begin
        prev_off++;
      end
    end
  end

  ////////////////////
  // stimulus
  ////////////////////
  // config is captured while reset is high
  task automatic apply_reset(input int n, input int mode);
    @(posedge clk);
    #1;
    checking = 1'b0;
    reset = 1'b1;
    fm_start = 1'b0;
    cfg_init.mode = mode[3:0];
    cfg_init.tile_len = n[15:0];
    exp_n = n;
    exp_mode = mode[3:0];
    cur_off = -1;
    prev_off = -1;
    done_pulses = 0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    // different config on the input, only the captured copy gives the right trace
    cfg_init = ~cfg_init;
    checking = 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // one-cycle start, new_tile restarts the reference
  task automatic pulse_start(input bit new_tile);
    @(posedge clk);
    #1;
    fm_start = 1'b1;
    if (new_tile) begin
      prev_off = cur_off;
      cur_off = 0;
    end
    @(posedge clk);
    #1;
    fm_start = 1'b0;
  endtask

  // tile_done or the receive reset that comes with seq_done
  task automatic wait_strobe(input bit tile_end);
    do begin
      @(negedge clk);
    end while (tile_end ? (post_ctrl.tile_done !== 1'b1)
                        : (post_ctrl.sum_e_receive_reset !== 1'b1));
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: pass", name);
    end else begin
      tests_failed++;
      $display("%s: fail, %0d mismatches", name, errors - errors_before);
    end
  endtask

  task automatic run_tile(input int n, input int mode);
    apply_reset(n, mode);
    idle_cycles(2);
    pulse_start(1'b1);
    wait_strobe(1'b1);
    idle_cycles(4);
    check_pulses(1);
  endtask

  ////////////////////
  // tests
  ////////////////////
  initial begin
    int base;
    int k;
    reset = 1'b1;
    fm_start = 1'b0;
    cfg_init = '0;
    checking = 1'b0;
    cur_off = -1;
    prev_off = -1;
    exp_n = 0;
    exp_mode = '0;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    done_pulses = 0;
    cycle_count = 0;
    seed = 51;
    for (k = 0; k < 5; k++) begin
      rand_n[k] = {$random(seed)} % 41;
      rand_mode[k] = {$random(seed)} % 3;
    end
    // N+45 per tile, idle test counted as N = 0
    timeout_limit = 200 + 45 + (4 + 45) + 45 + 2 * (3 + 45) + (6 + 45);
    for (k = 0; k < 5; k++) begin
      timeout_limit += rand_n[k] + 45;
    end

    // idle after reset
    base = errors;
    apply_reset(0, 0);
    idle_cycles(20);
    finish_test("test 1 idle after reset", base);

    base = errors;
    run_tile(4, 0);
    finish_test("test 2 single tile mode 0 N=4", base);

    base = errors;
    run_tile(0, int'(kernel_ctrl_pkg::MODE_MULT));
    finish_test("test 3 mult mode N=0", base);

    for (k = 0; k < 5; k++) begin
      base = errors;
      run_tile(rand_n[k], rand_mode[k]);
      finish_test($sformatf("test 4.%0d random tile N=%0d mode %0d", k, rand_n[k],
                            rand_mode[k]), base);
    end

    // second start one cycle after seq_done
    base = errors;
    apply_reset(3, int'(kernel_ctrl_pkg::MODE_MULT));
    idle_cycles(2);
    pulse_start(1'b1);
    wait_strobe(1'b0);
    pulse_start(1'b1);
    wait_strobe(1'b1);
    wait_strobe(1'b1);
    idle_cycles(4);
    check_pulses(2);
    finish_test("test 5 back-to-back tiles N=3", base);

    // extra start inside the pixel window is ignored
    base = errors;
    apply_reset(6, 0);
    idle_cycles(2);
    pulse_start(1'b1);
    pulse_start(1'b0);
    wait_strobe(1'b1);
    idle_cycles(4);
    check_pulses(1);
    finish_test("test 6 start during pixel window N=6", base);

    $display("tests passed %0d failed %0d, mismatches %0d", tests_passed, tests_failed, errors);
    if ((tests_failed == 0) && (errors == 0)) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
